/* source/addr_map_defs.svh */
/*
  build-time constants of the register window
  the base need not be aligned and the count need not be a power of 2
  AW_INDEX_WIDTH must cover AW_WINDOW_COUNT, and the count must fit the table
  of 2**AW_INDEX_WIDTH entries that the translator builds
*/

`ifndef ADDR_MAP_DEFS_SVH
`define ADDR_MAP_DEFS_SVH

// --------------------------------------------------
// bus side

// width of the flat bus address
`define AW_ADDR_WIDTH 16

// width of one stored register word
`define AW_DATA_WIDTH 32

// --------------------------------------------------
// window placement

// first address of the window, deliberately off any power-of-2 boundary
`define AW_WINDOW_BASE 16'h0013

// number of registers in the window, deliberately not a power of 2
`define AW_WINDOW_COUNT 11

// smallest local index width that still covers the count
`define AW_INDEX_WIDTH 4

`endif

/* source/addr_map_pkg.sv */
/*
  address-side types shared by decoder, translator and top level
  window_t is packed so that it can be passed as a parameter value
  base and count are each one bus-address-wide word
*/

`include "addr_map_defs.svh"

package addr_map_pkg;

    // --------------------------------------------------
    // addresses

    // a flat address as it arrives on the bus
    typedef logic [`AW_ADDR_WIDTH-1:0] bus_addr_t;

    // consecutive register number inside the window, 0 to count minus 1
    typedef logic [`AW_INDEX_WIDTH-1:0] local_index_t;

    // --------------------------------------------------
    // range description

    // one address range: the first address and the number of addresses
    // in it; the last address of the range is base plus count minus 1
    typedef struct packed {
        bus_addr_t base;
        bus_addr_t count;
    } window_t;

endpackage

/* source/reg_bank_pkg.sv */
/*
  data-side types of the register bank
  read_resp_t groups one read answer; miss is set for reads outside the window
  and the data of a miss is always zero
*/

`include "addr_map_defs.svh"

package reg_bank_pkg;

    // --------------------------------------------------
    // stored data

    // one register word as written and read over the bus
    typedef logic [`AW_DATA_WIDTH-1:0] reg_word_t;

    // --------------------------------------------------
    // read answer

    // what one read strobe returns a cycle later
    // data holds the register contents on a hit and zero on a miss
    typedef struct packed {
        reg_word_t data;
        logic      miss;
    } read_resp_t;

endpackage

/* source/window_access_if.sv */
/*
  access bundle between the address logic and the register bank
  purely combinational signals, no clock inside
  word_t has to match the entry type of the bank it feeds
*/

`timescale 1ns/1ps

interface window_access_if #(
    parameter type word_t = reg_bank_pkg::reg_word_t
);

    import addr_map_pkg::*;

    // address is inside the window, from the decoder
    logic         hit;
    // consecutive register number, from the translator
    local_index_t index;

    // one-cycle strobes and the write payload, from the top level
    logic         write;
    logic         read;
    word_t        wdata;

    // --------------------------------------------------
    // one view per block

    modport decoder (output hit);

    modport translator (output index);

    modport top (output write, read, wdata);

    modport bank (input hit, index, write, read, wdata);

endinterface

/* source/address_range_decoder.sv */
/*
  flags whether a bus address falls inside one window
  full-width compares, so aliases of the low bits elsewhere never hit
  a window reaching past the top of the address space is handled by
  computing the limit one bit wider
*/

`timescale 1ns/1ps

module address_range_decoder #(
    parameter addr_map_pkg::window_t WINDOW = '0
) (
    input  addr_map_pkg::bus_addr_t address,
    window_access_if.decoder        acc
);

    import addr_map_pkg::*;

    localparam int ADDR_W = $bits(bus_addr_t);

    // --------------------------------------------------
    // window bounds

    // one bit wider than the bus so that base plus count cannot wrap
    typedef logic [ADDR_W:0] wide_addr_t;

    localparam wide_addr_t LOWER = {1'b0, WINDOW.base};
    localparam wide_addr_t UPPER = {1'b0, WINDOW.base} + {1'b0, WINDOW.count};

    // --------------------------------------------------
    // compare

    wide_addr_t wide_address;
    logic       above_base;
    logic       below_limit;

    assign wide_address = {1'b0, address};

    // the base itself is the first address of the window
    assign above_base = (wide_address >= LOWER);

    // base plus count is the first address past the window
    assign below_limit = (wide_address < UPPER);

    // an empty window, count of zero, never hits since LOWER equals UPPER
    assign acc.hit = above_base && below_limit;

endmodule

/* source/address_range_translator.sv */
/*
  maps the low address bits to a consecutive local index, 0 to count minus 1
  the table is fixed at elaboration and reduces to rewiring or small logic
  no range check here, the decoder decides whether the index is meaningful
  count must not exceed the table depth of 2**index width
*/

`timescale 1ns/1ps

module address_range_translator #(
    parameter addr_map_pkg::window_t WINDOW = '0
) (
    input  addr_map_pkg::bus_addr_t address,
    window_access_if.translator     acc
);

    import addr_map_pkg::*;

    localparam int IDX_W       = $bits(local_index_t);
    localparam int TABLE_DEPTH = 2 ** IDX_W;

    // --------------------------------------------------
    // translation table

    // one local index per value of the low address bits
    typedef local_index_t table_t [TABLE_DEPTH];

    // the low bits of an unaligned window start at the base's low bits and
    // wrap around modulo the table depth, so the table is the identity map
    // rotated by that offset
    function automatic table_t build_table(window_t win);
        table_t      tbl;
        int unsigned slot;
        int unsigned entry;
        int unsigned step;
        // entries outside the window still need a defined value
        for (entry = 0; entry < TABLE_DEPTH; entry++) begin
            tbl[entry] = '0;
        end
        slot = int'(win.base[IDX_W-1:0]);
        for (step = 0; step < win.count; step++) begin
            tbl[slot] = local_index_t'(step);
            // wrap past the last table entry back to zero
            slot = (slot + 1) % TABLE_DEPTH;
        end
        return tbl;
    endfunction

    localparam table_t XLATE = build_table(WINDOW);

    // --------------------------------------------------
    // lookup

    logic [IDX_W-1:0] low_bits;

    // only the low bits select a register, the upper bits are the
    // decoder's business
    assign low_bits = address[IDX_W-1:0];

    assign acc.index = XLATE[low_bits];

endmodule

/* source/window_reg_bank.sv */
/*
  register array behind the window, one entry per local index
  writes land at the strobe edge when the address hits, other writes are dropped
  a read answers one cycle later; a miss returns zero data with rd_miss set
  stored entries have no reset and are undefined until written
  entry_t must be the word type of the connected access interface
*/

`timescale 1ns/1ps

module window_reg_bank #(
    parameter type entry_t = reg_bank_pkg::reg_word_t,
    parameter int  DEPTH   = 1
) (
    input  logic          clock,
    input  logic          rst_n,
    window_access_if.bank acc,
    output entry_t        rdata,
    output logic          rd_valid,
    output logic          rd_miss
);

    // --------------------------------------------------
    // storage

    entry_t mem [DEPTH];

    // the index is only trusted together with hit, which keeps it below
    // DEPTH even though the index field can count higher
    logic write_hit;
    logic read_hit;

    assign write_hit = acc.write && acc.hit;
    assign read_hit  = acc.read && acc.hit;

    always_ff @(posedge clock) begin
        if (write_hit) begin
            mem[acc.index] <= acc.wdata;
        end
    end

    // --------------------------------------------------
    // read response

    // rd_valid and rd_miss are single-cycle pulses that follow each read
    // strobe; rdata keeps the last answer until the next read
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            rd_miss  <= 1'b0;
            rdata    <= '0;
        end else begin
            rd_valid <= acc.read;
            rd_miss  <= acc.read && !acc.hit;
            if (read_hit) begin
                // contents as of this edge, a write cannot share the cycle
                rdata <= mem[acc.index];
            end else if (acc.read) begin
                // outside the window the answer is always zero
                rdata <= '0;
            end
        end
    end

endmodule

/* source/address_window.sv */
/*
  top level of the register window, plain ports only
  decoder and translator see the same live address in parallel and the
  bank combines hit and index at the clock edge
  write and read must not be asserted in the same cycle
  window placement and sizes come from the build-time macros
*/

`timescale 1ns/1ps

`include "addr_map_defs.svh"

module address_window (
    input  logic                    clock,
    input  logic                    rst_n,
    input  addr_map_pkg::bus_addr_t address,
    input  logic                    write,
    input  logic                    read,
    input  reg_bank_pkg::reg_word_t wdata,
    output reg_bank_pkg::reg_word_t rdata,
    output logic                    rd_valid,
    output logic                    rd_miss
);

    import addr_map_pkg::*;
    import reg_bank_pkg::*;

    // --------------------------------------------------
    // window description

    // one description feeds both decoder and translator so they cannot
    // disagree about where the window sits
    localparam window_t WINDOW = '{
        base:  bus_addr_t'(`AW_WINDOW_BASE),
        count: bus_addr_t'(`AW_WINDOW_COUNT)
    };

    // --------------------------------------------------
    // access bundle

    window_access_if #(.word_t(reg_word_t)) acc ();

    // strobes and payload pass straight in, no staging
    assign acc.write = write;
    assign acc.read  = read;
    assign acc.wdata = wdata;

    // --------------------------------------------------
    // address side, zero cycles from address to hit and index

    address_range_decoder #(
        .WINDOW (WINDOW)
    ) decoder_i (
        .address (address),
        .acc     (acc)
    );

    address_range_translator #(
        .WINDOW (WINDOW)
    ) translator_i (
        .address (address),
        .acc     (acc)
    );

    // --------------------------------------------------
    // storage and registered read answer

    window_reg_bank #(
        .entry_t (reg_word_t),
        .DEPTH   (`AW_WINDOW_COUNT)
    ) bank_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .acc      (acc),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .rd_miss  (rd_miss)
    );

endmodule

/* sim/address_window_assert.sv */
/*
  protocol rules of the read response, bound to every register bank
  read is the strobe as the bank sees it through the access interface
  checks are disabled while rst_n is low
*/

`timescale 1ns/1ps

module address_window_assert (
    input logic                    clock,
    input logic                    rst_n,
    input logic                    read,
    input logic                    rd_valid,
    input logic                    rd_miss,
    input reg_bank_pkg::reg_word_t rdata
);

    // --------------------------------------------------
    // response timing

    // every read strobe is answered on the very next cycle
    valid_follows_read: assert property (
        @(posedge clock) disable iff (!rst_n) read |=> rd_valid
    ) else $error("rd_valid did not follow a read strobe by one cycle");

    // two valid cycles in a row need two strobes in a row behind them
    no_stretched_valid: assert property (
        @(posedge clock) disable iff (!rst_n)
        (rd_valid && $past(rd_valid)) |-> ($past(read, 1) && $past(read, 2))
    ) else $error("rd_valid stayed high without a second read strobe");

    // --------------------------------------------------
    // response content

    // a miss never leaks stale register contents
    miss_has_zero_data: assert property (
        @(posedge clock) disable iff (!rst_n) (rd_valid && rd_miss) |-> (rdata == '0)
    ) else $error("miss response carried nonzero data");

endmodule

bind window_reg_bank address_window_assert assert_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .read     (acc.read),
    .rd_valid (rd_valid),
    .rd_miss  (rd_miss),
    .rdata    (rdata)
);

/* sim/tb_address_window.sv */
/*
  self-checking testbench of the register window top level
  expected values follow the window rules: a hit is base to base plus count
  minus 1 and the register is address minus base, everything else misses
  inputs change 1 ns after a rising edge, results are sampled there too
  the run stops at the first error
*/

`timescale 1ns/1ps

`include "addr_map_defs.svh"

module tb_address_window;

    import addr_map_pkg::*;
    import reg_bank_pkg::*;

    localparam int unsigned BASE           = `AW_WINDOW_BASE;
    localparam int unsigned COUNT          = `AW_WINDOW_COUNT;
    localparam int          TIMEOUT_CYCLES = 4;
    localparam int          RANDOM_OPS     = 200;

    logic      clock;
    logic      rst_n;
    bus_addr_t address;
    logic      write;
    logic      read;
    reg_word_t wdata;
    reg_word_t rdata;
    logic      rd_valid;
    logic      rd_miss;

    // one table row; exp_data and exp_miss only matter for reads
    typedef struct packed {
        logic      is_write;
        bus_addr_t addr;
        reg_word_t wdata;
        reg_word_t exp_data;
        logic      exp_miss;
    } stim_t;

    stim_t       stim_table [$];
    reg_word_t   ref_mem [COUNT];
    logic [31:0] lcg_state;

    address_window dut_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .address  (address),
        .write    (write),
        .read     (read),
        .wdata    (wdata),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .rd_miss  (rd_miss)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // --------------------------------------------------
    // reporting and compares

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input reg_word_t got, input reg_word_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s data expected %h got %h",
                                     $time, what, exp, got));
        end
    endtask

    task automatic check_miss(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s rd_miss expected %b got %b",
                                     $time, what, exp, got));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s rd_valid expected %b got %b",
                                     $time, what, exp, got));
        end
    endtask

    // --------------------------------------------------
    // reference model

    function automatic logic in_window(input bus_addr_t a);
        int unsigned ai;
        ai = a;
        return (ai >= BASE) && (ai < BASE + COUNT);
    endfunction

    // distinct per address, both halves depend on every address bit
    function automatic reg_word_t data_pattern(input bus_addr_t a);
        return reg_word_t'({~a, a});
    endfunction

    function automatic reg_word_t expected_data(input bus_addr_t a);
        if (in_window(a)) begin
            return ref_mem[int'(a) - int'(BASE)];
        end
        return '0;
    endfunction

    // full-period LCG with the usual 32-bit constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic model_write(input bus_addr_t a, input reg_word_t d);
        if (in_window(a)) begin
            ref_mem[int'(a) - int'(BASE)] = d;
        end
    endtask

    // --------------------------------------------------
    // bus drivers, each starts and ends 1 ns after a rising edge

    task automatic drive_write(input bus_addr_t a, input reg_word_t d);
        address = a;
        wdata   = d;
        write   = 1'b1;
        @(posedge clock);
        #1;
        write = 1'b0;
    endtask

    // polls rd_valid once per cycle and gives up after max_wait extra cycles
    task automatic wait_response(input int max_wait);
        int waited;
        waited = 0;
        while (rd_valid !== 1'b1) begin
            if (waited >= max_wait) begin
                report_failure($sformatf("no read response arrived within %0d cycles, time %0t",
                                         max_wait, $time));
            end else begin
                @(posedge clock);
                #1;
                waited++;
            end
        end
    endtask

    task automatic read_and_check(input bus_addr_t a, input reg_word_t exp_data,
                                  input logic exp_miss, input string what);
        address = a;
        read    = 1'b1;
        @(posedge clock);
        #1;
        read = 1'b0;
        wait_response(TIMEOUT_CYCLES);
        check_word(rdata, exp_data, what);
        check_miss(rd_miss, exp_miss, what);
    endtask

    // --------------------------------------------------
    // stimulus table

    task automatic add_write(input bus_addr_t a, input reg_word_t d);
        stim_table.push_back('{1'b1, a, d, '0, 1'b0});
    endtask

    task automatic add_read(input bus_addr_t a, input reg_word_t exp, input logic miss);
        stim_table.push_back('{1'b0, a, '0, exp, miss});
    endtask

    task automatic build_table();
        bus_addr_t outside [4];
        int        i;
        outside[0] = bus_addr_t'(BASE - 1);
        outside[1] = bus_addr_t'(BASE + COUNT);
        // low bits alias entries inside the window
        outside[2] = bus_addr_t'(BASE + 16'h0100);
        outside[3] = bus_addr_t'(BASE + 16);
        // fill the whole window, then read it back across the index wrap
        for (i = 0; i < COUNT; i++) begin
            add_write(bus_addr_t'(BASE + i), data_pattern(bus_addr_t'(BASE + i)));
        end
        for (i = 0; i < COUNT; i++) begin
            add_read(bus_addr_t'(BASE + i), data_pattern(bus_addr_t'(BASE + i)), 1'b0);
        end
        // reads next to and aliasing the window miss with zero data
        for (i = 0; i < 4; i++) begin
            add_read(outside[i], '0, 1'b1);
        end
        // stray writes must not reach any register
        for (i = 0; i < 4; i++) begin
            add_write(outside[i], reg_word_t'({outside[i], 16'hbad0}));
        end
        for (i = 0; i < COUNT; i++) begin
            add_read(bus_addr_t'(BASE + i), data_pattern(bus_addr_t'(BASE + i)), 1'b0);
        end
    endtask

    task automatic apply_table();
        int i;
        for (i = 0; i < stim_table.size(); i++) begin
            if (stim_table[i].is_write) begin
                drive_write(stim_table[i].addr, stim_table[i].wdata);
                model_write(stim_table[i].addr, stim_table[i].wdata);
            end else begin
                read_and_check(stim_table[i].addr, stim_table[i].exp_data,
                               stim_table[i].exp_miss, $sformatf("table row %0d", i));
            end
        end
    endtask

    // --------------------------------------------------
    // back-to-back reads and random mix

    // one strobe per cycle, each answer must sit on the following cycle
    task automatic run_burst();
        bus_addr_t burst [$];
        int        i;
        for (i = 0; i < COUNT; i++) begin
            burst.push_back(bus_addr_t'(BASE + i));
            if (i == COUNT / 2) begin
                burst.push_back(bus_addr_t'(BASE - 1));
            end
        end
        burst.push_back(bus_addr_t'(BASE + COUNT));
        for (i = 0; i < burst.size(); i++) begin
            address = burst[i];
            read    = 1'b1;
            @(posedge clock);
            #1;
            wait_response(0);
            check_word(rdata, expected_data(burst[i]), $sformatf("burst read %0d", i));
            check_miss(rd_miss, !in_window(burst[i]), $sformatf("burst read %0d", i));
        end
        read = 1'b0;
        @(posedge clock);
        #1;
        check_valid(rd_valid, 1'b0, "cycle after burst");
    endtask

    task automatic run_random_mix();
        bus_addr_t a;
        int        n;
        for (n = 0; n < RANDOM_OPS; n++) begin
            lcg_state = lcg_next(lcg_state);
            // span from 8 below the base to 8 past the end of the window
            a = bus_addr_t'(BASE - 8 + (lcg_state[23:16] % (COUNT + 16)));
            // now and then move far away with the same low bits
            if (lcg_state[30:28] == 3'd0) begin
                a = a ^ bus_addr_t'(16'h4000);
            end
            lcg_state = lcg_next(lcg_state);
            if (lcg_state[31]) begin
                drive_write(a, reg_word_t'(lcg_state));
                model_write(a, reg_word_t'(lcg_state));
            end else begin
                read_and_check(a, expected_data(a), !in_window(a),
                               $sformatf("random op %0d at %h", n, a));
            end
        end
    endtask

    // --------------------------------------------------
    // sequence

    initial begin
        rst_n       = 1'b0;
        address     = '0;
        write       = 1'b0;
        read        = 1'b0;
        wdata       = '0;
        lcg_state   = 32'h1288e576;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;
        // response outputs are quiet before any read
        check_valid(rd_valid, 1'b0, "after reset");
        check_miss(rd_miss, 1'b0, "after reset");
        check_word(rdata, '0, "after reset");
        @(posedge clock);
        #1;
        check_valid(rd_valid, 1'b0, "idle cycle after reset");
        check_miss(rd_miss, 1'b0, "idle cycle after reset");
        build_table();
        apply_table();
        run_burst();
        run_random_mix();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/addr_map_pkg.sv
source/reg_bank_pkg.sv
source/window_access_if.sv
source/address_range_decoder.sv
source/address_range_translator.sv
source/window_reg_bank.sv
source/address_window.sv
sim/address_window_assert.sv
sim/tb_address_window.sv

/* Bender.yml */
package:
  name: address_window

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/addr_map_pkg.sv
      - source/reg_bank_pkg.sv
      - source/window_access_if.sv
      - source/address_range_decoder.sv
      - source/address_range_translator.sv
      - source/window_reg_bank.sv
      - source/address_window.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/address_window_assert.sv
      - sim/tb_address_window.sv
